// File: Bender.yml
package:
  name: drive_ctrl

sources:
  - src/spi_pkg.sv
  - src/motor_pkg.sv
  - src/reg_bus_if.sv
  - src/spi_target.sv
  - src/reg_file.sv
  - src/pwm_bank.sv
  - src/drive_top.sv
  - target: test
    files:
      - bench/drive_checker.sv
      - bench/drive_tb.sv

// File: bench/drive_checker.sv
// Watches the motor controller pins, keeps a register model and compares
// SPI read data and PWM / LED high counts against the model
`timescale 1ns/1ps

module drive_checker #(
    parameter int PWM_PRESCALE = 2                  // Must match the DUT
) (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       spi_clock,
    input  logic       cs_n,
    input  logic       mosi,
    input  logic       miso,
    input  logic [3:0] sd_pwm,
    input  logic [3:0] sd_dir,
    input  logic       status_fault,
    input  logic       status_pi,
    input  logic       status_ps4,
    input  logic       status_debug,
    output int         error_count,
    output int         check_count,
    output int         window_checks                // Steady windows compared
);

    localparam int window = 64 * PWM_PRESCALE;      // One PWM period in clocks
    localparam int settle = 2 * window + 4;         // Latch at period start plus a full window

    spi_pkg::data_t model_reg [6];                  // Addresses 0x00 to 0x05
    logic [15:0]    mosi_bits   = '0;
    spi_pkg::data_t miso_bits   = '0;
    int             bit_count   = 0;
    int             write_count = 0;                // Writes decoded from SPI
    int             seen_writes = 0;
    int             quiet;                          // Clocks since last write
    int             win_cnt;
    int             pwm_high [4];
    int             debug_high, fault_high, pi_high, ps4_high;
    bit             reset_seen;

    initial begin
        error_count   = 0;
        check_count   = 0;
        window_checks = 0;
        for (int i = 0; i < 6; i++) begin
            model_reg[i] = '0;                      // All registers reset to 0
        end
    end

    task automatic compare(input string name, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("** Error at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic spi_pkg::data_t expected_read(input spi_pkg::addr_t addr);
        if (addr == motor_pkg::addr_id) begin
            return motor_pkg::id_value;
        end
        if (addr <= motor_pkg::addr_led_mask) begin
            return model_reg[int'(addr)];
        end
        return '0;                                  // Unmapped
    endfunction

    function automatic void model_write(input spi_pkg::addr_t addr, input spi_pkg::data_t data);
        if (addr == motor_pkg::addr_led_level) begin
            model_reg[int'(addr)] = data & 8'h0f;   // Low nibble kept
        end else if (addr == motor_pkg::addr_led_mask) begin
            model_reg[int'(addr)] = data & 8'h07;   // Three mask bits
        end else if (addr < motor_pkg::addr_led_level) begin
            model_reg[int'(addr)] = data;           // Drive bytes
        end
    endfunction

    task automatic finish_frame();
        spi_pkg::data_t cmd;
        spi_pkg::addr_t addr;
        cmd  = mosi_bits[15:8];
        addr = cmd[spi_pkg::addr_width-1:0];        // Bit 6 ignored
        if (cmd[spi_pkg::read_flag_bit]) begin
            compare($sformatf("miso read 0x%02h", addr), expected_read(addr), miso_bits);
        end else begin
            model_write(addr, mosi_bits[7:0]);
            write_count++;
        end
    endtask

    // Frame decode straight from the SPI pins
    always @(posedge spi_clock or posedge cs_n) begin
        if (cs_n) begin
            bit_count = 0;                          // Partial frames dropped
        end else begin
            mosi_bits = {mosi_bits[14:0], mosi};
            miso_bits = {miso_bits[6:0], miso};     // Last 8 are byte 2
            bit_count++;
            if (bit_count == spi_pkg::frame_bits) begin
                finish_frame();                     // DUT acts on the 16th rise
            end
        end
    end

    //////////////////////////////
    // PWM window counts
    //////////////////////////////
    task automatic check_window();
        motor_pkg::drive_ctrl_u ctrl;
        int                     level_high;
        for (int i = 0; i < motor_pkg::num_drive; i++) begin
            ctrl.raw = model_reg[i];
            compare($sformatf("sd_pwm[%0d] high clocks", i),
                    ctrl.ctrl.enable ? int'(ctrl.ctrl.ratio) * PWM_PRESCALE : 0, pwm_high[i]);
            compare($sformatf("sd_dir[%0d]", i), ctrl.ctrl.dir, sd_dir[i]);
        end
        level_high = int'(model_reg[4][3:0]) * 4 * PWM_PRESCALE;  // 4 steps per level
        compare("status_debug high clocks", level_high, debug_high);
        compare("status_fault high clocks", model_reg[5][0] ? level_high : 0, fault_high);
        compare("status_pi high clocks", model_reg[5][1] ? level_high : 0, pi_high);
        compare("status_ps4 high clocks", model_reg[5][2] ? level_high : 0, ps4_high);
        window_checks++;
    endtask

    task automatic clear_counts();
        for (int i = 0; i < 4; i++) begin
            pwm_high[i] = 0;
        end
        debug_high = 0;
        fault_high = 0;
        pi_high    = 0;
        ps4_high   = 0;
        win_cnt    = 0;
    endtask

    // Registered outputs sampled mid-cycle
    always @(negedge clock) begin
        if (!reset_n) begin
            quiet      = 0;
            reset_seen = 1'b0;
            clear_counts();
        end else begin
            if (!reset_seen) begin
                compare("outputs after reset", 0, {miso, sd_pwm, sd_dir, status_fault,
                        status_pi, status_ps4, status_debug});
                reset_seen = 1'b1;
            end
            if (write_count != seen_writes) begin
                seen_writes = write_count;
                quiet       = 0;                    // Settings moved, restart settling
            end else if (quiet < settle) begin
                quiet++;
            end
            for (int i = 0; i < 4; i++) begin
                pwm_high[i] += int'(sd_pwm[i]);
            end
            debug_high += int'(status_debug);
            fault_high += int'(status_fault);
            pi_high    += int'(status_pi);
            ps4_high   += int'(status_ps4);
            win_cnt++;
            if (win_cnt == window) begin
                if (quiet >= settle) begin
                    check_window();
                end
                clear_counts();
            end
        end
    end

endmodule

// File: bench/drive_tb.sv
// Testbench for the SPI motor controller, bit-bangs SPI frames into the DUT
// Comparing is done by drive_checker, this module reports the result
`timescale 1ns/1ps

module drive_tb;

    localparam int          prescale       = 2;     // Short PWM period, 128 clocks
    localparam int          spi_half       = 10;    // Clocks per SPI half period
    localparam logic [31:0] seed           = 32'hc3df_5ad3;
    localparam int          window_timeout = 2000;  // Clocks to wait for window checks

    logic       clock;
    logic       reset_n;
    logic       spi_clock;
    logic       cs_n;
    logic       mosi;
    logic       miso;
    logic [3:0] sd_pwm;
    logic [3:0] sd_dir;
    logic       status_fault, status_pi, status_ps4, status_debug;
    int         error_count, check_count, window_checks;
    bit         timed_out;

    drive_top #(
        .PWM_PRESCALE (prescale)
    ) UUT (
        .clock        (clock),
        .reset_n      (reset_n),
        .spi_clock    (spi_clock),
        .cs_n         (cs_n),
        .mosi         (mosi),
        .miso         (miso),
        .sd_pwm       (sd_pwm),
        .sd_dir       (sd_dir),
        .status_fault (status_fault),
        .status_pi    (status_pi),
        .status_ps4   (status_ps4),
        .status_debug (status_debug)
    );

    drive_checker #(
        .PWM_PRESCALE (prescale)
    ) u_checker (
        .clock         (clock),
        .reset_n       (reset_n),
        .spi_clock     (spi_clock),
        .cs_n          (cs_n),
        .mosi          (mosi),
        .miso          (miso),
        .sd_pwm        (sd_pwm),
        .sd_dir        (sd_dir),
        .status_fault  (status_fault),
        .status_pi     (status_pi),
        .status_ps4    (status_ps4),
        .status_debug  (status_debug),
        .error_count   (error_count),
        .check_count   (check_count),
        .window_checks (window_checks)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;                  // 8 ns period
    end

    //////////////////////////////
    // SPI host tasks
    //////////////////////////////
    task automatic half_period();
        repeat (spi_half) @(negedge clock);
    endtask

    // Mode 0, MSB first, miso taken on each rising spi_clock of byte 2
    task automatic spi_frame(input logic [15:0] frame, output spi_pkg::data_t rx);
        rx   = '0;
        cs_n = 1'b0;
        half_period();
        for (int i = 15; i >= 0; i--) begin
            mosi = frame[i];
            half_period();
            spi_clock = 1'b1;
            if (i < 8) begin
                rx = {rx[6:0], miso};
            end
            half_period();
            spi_clock = 1'b0;
        end
        half_period();
        cs_n = 1'b1;
        mosi = 1'b0;
        half_period();                              // Gap between frames
    endtask

    task automatic spi_write(input spi_pkg::addr_t addr, input spi_pkg::data_t data);
        spi_pkg::data_t cmd;
        spi_pkg::data_t unused;
        cmd    = {2'b00, addr};
        cmd[6] = $urandom_range(1, 0);              // Undecoded bit
        spi_frame({cmd, data}, unused);
    endtask

    task automatic spi_read(input spi_pkg::addr_t addr, output spi_pkg::data_t data);
        spi_pkg::data_t cmd;
        cmd                        = {2'b00, addr};
        cmd[spi_pkg::read_flag_bit] = 1'b1;
        cmd[6]                     = $urandom_range(1, 0);
        spi_frame({cmd, 8'h00}, data);
    endtask

    task automatic wait_windows(input int count);
        int target;
        int cycles;
        target = window_checks + count;
        cycles = 0;
        while (window_checks < target && cycles < window_timeout) begin
            @(negedge clock);
            cycles++;
        end
        if (window_checks < target) begin
            $display("Timeout: PWM window checks did not complete within %0d clocks", cycles);
            timed_out = 1'b1;
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin
        spi_pkg::data_t rd_byte;
        spi_pkg::data_t data;
        spi_pkg::addr_t addr;
        void'($urandom(seed));
        reset_n   = 1'b0;
        spi_clock = 1'b0;
        cs_n      = 1'b1;
        mosi      = 1'b0;
        timed_out = 1'b0;
        repeat (10) @(negedge clock);
        reset_n = 1'b1;
        repeat (5) @(negedge clock);

        for (int a = 0; a <= 5; a++) begin
            spi_read(spi_pkg::addr_t'(a), rd_byte);  // Reset values
        end

        repeat (2) begin
            for (int a = 0; a <= 5; a++) begin
                spi_write(spi_pkg::addr_t'(a), spi_pkg::data_t'($urandom));
            end
            for (int a = 0; a <= 6; a++) begin
                spi_read(spi_pkg::addr_t'(a), rd_byte);
            end
        end
        spi_write(motor_pkg::addr_id, spi_pkg::data_t'($urandom));  // Read only
        spi_read(motor_pkg::addr_id, rd_byte);
        repeat (4) begin
            addr = spi_pkg::addr_t'($urandom_range(63, 7));
            spi_write(addr, spi_pkg::data_t'($urandom));
            spi_read(addr, rd_byte);
        end

        // Steady settings, alternate channels enabled each round
        for (int round = 0; round < 3; round++) begin
            if (!timed_out) begin
                for (int a = 0; a < motor_pkg::num_drive; a++) begin
                    data    = spi_pkg::data_t'($urandom);
                    data[7] = ((a + round) % 2) == 0;
                    spi_write(spi_pkg::addr_t'(a), data);
                end
                spi_write(motor_pkg::addr_led_level, spi_pkg::data_t'($urandom));
                spi_write(motor_pkg::addr_led_mask, spi_pkg::data_t'($urandom));
                wait_windows(2);
            end
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
                 timed_out);
        if (error_count == 0 && !timed_out && check_count > 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: sim.f
src/spi_pkg.sv
src/motor_pkg.sv
src/reg_bus_if.sv
src/spi_target.sv
src/reg_file.sv
src/pwm_bank.sv
src/drive_top.sv
bench/drive_checker.sv
bench/drive_tb.sv

// File: src/drive_top.sv
// Top level of the SPI driven motor controller
// SPI target feeds the register file, which sets the PWM bank
`timescale 1ns/1ps

module drive_top #(
    parameter int PWM_PRESCALE = 32                 // Clocks per PWM step
) (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       spi_clock,
    input  logic       cs_n,
    input  logic       mosi,
    output logic       miso,
    output logic [3:0] sd_pwm,
    output logic [3:0] sd_dir,
    output logic       status_fault,
    output logic       status_pi,
    output logic       status_ps4,
    output logic       status_debug
);

    motor_pkg::drive_ctrl_u drive [motor_pkg::num_drive];  // Drive registers
    motor_pkg::led_level_t  led_level;
    motor_pkg::led_mask_t   led_mask;

    reg_bus_if bus_if ();

    //////////////////////////////
    // Input side
    //////////////////////////////
    spi_target u_spi (
        .clock     (clock),
        .reset_n   (reset_n),
        .spi_clock (spi_clock),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .miso      (miso),
        .bus       (bus_if.target)
    );

    reg_file u_regs (
        .clock     (clock),
        .reset_n   (reset_n),
        .bus       (bus_if.regs),
        .drive     (drive),
        .led_level (led_level),
        .led_mask  (led_mask)
    );

    //////////////////////////////
    // Output side
    //////////////////////////////
    pwm_bank #(
        .PWM_PRESCALE (PWM_PRESCALE)
    ) u_pwm (
        .clock        (clock),
        .reset_n      (reset_n),
        .drive        (drive),
        .led_level    (led_level),
        .led_mask     (led_mask),
        .sd_pwm       (sd_pwm),
        .sd_dir       (sd_dir),
        .status_fault (status_fault),
        .status_pi    (status_pi),
        .status_ps4   (status_ps4),
        .status_debug (status_debug)
    );

endmodule

// File: src/motor_pkg.sv
// Register map and drive control layout of the motor controller
// Also holds the PWM step width used by the output stage

package motor_pkg;

    localparam int num_drive = 4;                   // Drive motor channels

    ////////////////////////////////
    // Register map
    ////////////////////////////////
    localparam spi_pkg::addr_t addr_drive0    = 6'h00;  // Drive channel 0
    localparam spi_pkg::addr_t addr_drive1    = 6'h01;  // Drive channel 1
    localparam spi_pkg::addr_t addr_drive2    = 6'h02;  // Drive channel 2
    localparam spi_pkg::addr_t addr_drive3    = 6'h03;  // Drive channel 3
    localparam spi_pkg::addr_t addr_led_level = 6'h04;  // LED brightness, low nibble only
    localparam spi_pkg::addr_t addr_led_mask  = 6'h05;  // LED enable mask, 3 bits
    localparam spi_pkg::addr_t addr_id        = 6'h06;  // Identity, read only

    localparam spi_pkg::data_t id_value = 8'hA5;    // Identity byte

    // Bit positions inside the LED mask
    localparam int led_fault_bit = 0;
    localparam int led_pi_bit    = 1;
    localparam int led_ps4_bit   = 2;

    typedef logic [5:0] drive_ratio_t;              // High steps per period
    typedef logic [3:0] led_level_t;                // LED brightness
    typedef logic [2:0] led_mask_t;                 // LED enables
    typedef logic [5:0] pwm_step_t;                 // 64 steps per PWM period

    typedef struct packed {
        logic         enable;                       // Bit 7
        logic         dir;                          // Bit 6
        drive_ratio_t ratio;                        // Bits 5:0
    } drive_fields_t;

    // Same byte seen by the bus as raw data and by the PWM stage as fields
    typedef union packed {
        spi_pkg::data_t raw;
        drive_fields_t  ctrl;
    } drive_ctrl_u;

endpackage

// File: src/pwm_bank.sv
// Drive motor PWM channels and dimmed status LEDs on one shared step counter
// New settings take effect at the next period start
`timescale 1ns/1ps

module pwm_bank #(
    parameter int PWM_PRESCALE = 32                 // Clocks per PWM step
) (
    input  logic                   clock,
    input  logic                   reset_n,
    input  motor_pkg::drive_ctrl_u drive [motor_pkg::num_drive],
    input  motor_pkg::led_level_t  led_level,
    input  motor_pkg::led_mask_t   led_mask,
    output logic [3:0]             sd_pwm,          // Drive PWM waves
    output logic [3:0]             sd_dir,          // Drive direction levels
    output logic                   status_fault,
    output logic                   status_pi,
    output logic                   status_ps4,
    output logic                   status_debug     // Undimmed by mask
);

    localparam int pre_width = (PWM_PRESCALE > 1) ? $clog2(PWM_PRESCALE) : 1;
    localparam int lvl_width = $bits(motor_pkg::led_level_t);

    logic [pre_width-1:0]            pre_cnt;
    logic                            step_tick;     // Step advances
    logic                            period_end;    // Step wraps to 0
    motor_pkg::pwm_step_t            step;
    logic [motor_pkg::num_drive-1:0] lat_en;        // Enables taken at period start
    motor_pkg::drive_ratio_t         lat_ratio [motor_pkg::num_drive];
    motor_pkg::led_level_t           lat_level;
    logic                            led_wave;

    assign step_tick  = (pre_cnt == pre_width'(PWM_PRESCALE - 1));
    assign period_end = step_tick & (step == '1);
    assign led_wave   = step[$bits(motor_pkg::pwm_step_t)-1 -: lvl_width] < lat_level;

    always_comb begin
        for (int i = 0; i < motor_pkg::num_drive; i++) begin
            sd_dir[i] = drive[i].ctrl.dir;          // Follows register, enable or not
        end
    end

    ////////////////////////////////
    // Prescaler, step and latches
    ////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pre_cnt   <= '0;
            step      <= '0;
            lat_en    <= '0;
            lat_level <= '0;
            for (int i = 0; i < motor_pkg::num_drive; i++) begin
                lat_ratio[i] <= '0;
            end
        end else begin
            pre_cnt <= step_tick ? '0 : pre_cnt + 1'b1;
            if (step_tick) begin
                step <= step + 1'b1;                // 64 steps per period
            end
            if (period_end) begin
                lat_level <= led_level;
                for (int i = 0; i < motor_pkg::num_drive; i++) begin
                    lat_en[i]    <= drive[i].ctrl.enable;
                    lat_ratio[i] <= drive[i].ctrl.ratio;
                end
            end
        end
    end

    // Registered outputs, glitch free toward the motor drivers
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            sd_pwm       <= '0;
            status_debug <= 1'b0;
            status_fault <= 1'b0;
            status_pi    <= 1'b0;
            status_ps4   <= 1'b0;
        end else begin
            for (int i = 0; i < motor_pkg::num_drive; i++) begin
                sd_pwm[i] <= lat_en[i] & (step < lat_ratio[i]);
            end
            status_debug <= led_wave;
            status_fault <= led_wave & led_mask[motor_pkg::led_fault_bit];
            status_pi    <= led_wave & led_mask[motor_pkg::led_pi_bit];
            status_ps4   <= led_wave & led_mask[motor_pkg::led_ps4_bit];
        end
    end

    // Output lags the latch by a clock, step 63 keeps the edge low
    for (genvar g = 0; g < motor_pkg::num_drive; g++) begin : g_en_check
        pwm_needs_enable: assert property (
            @(posedge clock) disable iff (!reset_n) sd_pwm[g] |-> lat_en[g]
        );
    end

endmodule

// File: src/reg_bus_if.sv
// Register bus between the SPI target and the register file
// Plain one-cycle strobes, read data returns one clock after read_en
`timescale 1ns/1ps

interface reg_bus_if;

    spi_pkg::addr_t address;                        // Read / write address
    logic           write_en;                       // Write strobe, one cycle
    spi_pkg::data_t wr_data;                        // Write data
    logic           read_en;                        // Read strobe, one cycle
    spi_pkg::data_t rd_data;                        // Read data, registered

    // SPI side issues the strobes
    modport target (output address, write_en, wr_data, read_en, input rd_data);

    // Register side answers reads
    modport regs (input address, write_en, wr_data, read_en, output rd_data);

endinterface

// File: src/reg_file.sv
// Control registers of the motor controller behind the register bus
// Writes land on the write_en edge, reads return one clock after read_en
`timescale 1ns/1ps

module reg_file (
    input  logic                   clock,
    input  logic                   reset_n,
    reg_bus_if.regs                bus,
    output motor_pkg::drive_ctrl_u drive [motor_pkg::num_drive],
    output motor_pkg::led_level_t  led_level,
    output motor_pkg::led_mask_t   led_mask
);

    spi_pkg::data_t rd_value;                       // Read mux output

    ////////////////////////////////
    // Write decode
    ////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < motor_pkg::num_drive; i++) begin
                drive[i].raw <= '0;
            end
            led_level <= '0;
            led_mask  <= '0;
        end else if (bus.write_en) begin
            case (bus.address)
                motor_pkg::addr_drive0:    drive[0].raw <= bus.wr_data;
                motor_pkg::addr_drive1:    drive[1].raw <= bus.wr_data;
                motor_pkg::addr_drive2:    drive[2].raw <= bus.wr_data;
                motor_pkg::addr_drive3:    drive[3].raw <= bus.wr_data;
                motor_pkg::addr_led_level: begin
                    led_level <= bus.wr_data[$bits(motor_pkg::led_level_t)-1:0];
                end
                motor_pkg::addr_led_mask:  begin
                    led_mask <= bus.wr_data[$bits(motor_pkg::led_mask_t)-1:0];
                end
                default: ;                          // Identity and unmapped ignored
            endcase
        end
    end

    ////////////////////////////////
    // Read mux
    ////////////////////////////////
    always_comb begin
        case (bus.address)
            motor_pkg::addr_drive0:    rd_value = drive[0].raw;
            motor_pkg::addr_drive1:    rd_value = drive[1].raw;
            motor_pkg::addr_drive2:    rd_value = drive[2].raw;
            motor_pkg::addr_drive3:    rd_value = drive[3].raw;
            motor_pkg::addr_led_level: rd_value = spi_pkg::data_t'(led_level);  // Upper bits 0
            motor_pkg::addr_led_mask:  rd_value = spi_pkg::data_t'(led_mask);
            motor_pkg::addr_id:        rd_value = motor_pkg::id_value;
            default:                   rd_value = '0;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            bus.rd_data <= '0;
        end else if (bus.read_en) begin
            bus.rd_data <= rd_value;                // Valid the clock after read_en
        end
    end

    // SPI target issues one strobe per frame byte, never both
    strobes_exclusive: assert property (
        @(posedge clock) disable iff (!reset_n) !(bus.write_en && bus.read_en)
    );

endmodule

// File: src/spi_pkg.sv
// Frame format and bus widths shared by the SPI target and the register file
// Referenced by scoped names, no import

package spi_pkg;

    ////////////////////////////////
    // Register bus widths
    ////////////////////////////////
    localparam int addr_width = 6;                  // Register address bits
    localparam int data_width = 8;                  // Data byte bits

    typedef logic [addr_width-1:0] addr_t;          // Register address
    typedef logic [data_width-1:0] data_t;          // Data byte

    ////////////////////////////////
    // SPI frame layout
    ////////////////////////////////
    // Byte 1 holds the command, byte 2 the data or a dummy for reads.
    // Bit 6 of the command byte is not decoded.
    localparam int read_flag_bit = 7;               // 1 read, 0 write
    localparam int frame_bits    = 16;              // Bits per frame

endpackage

// File: src/spi_target.sv
// SPI mode 0 target that turns 16-bit frames into register bus strobes
// SPI pins are oversampled by clock, half period of spi_clock at least 8 clocks
`timescale 1ns/1ps

module spi_target (
    input  logic      clock,
    input  logic      reset_n,
    input  logic      spi_clock,                    // SPI clock from the host
    input  logic      cs_n,                         // Active low chip select
    input  logic      mosi,                         // Sampled on rising spi_clock
    output logic      miso,                         // Changes on falling spi_clock
    reg_bus_if.target bus
);

    localparam int cnt_width = $clog2(spi_pkg::frame_bits);

    logic [2:0]           sclk_sync;                // Two sync stages plus edge history
    logic [1:0]           cs_sync;
    logic [1:0]           mosi_sync;
    logic                 sclk_rise;
    logic                 sclk_fall;
    logic                 cs_idle;                  // Synced cs_n
    logic                 mosi_s;
    logic [cnt_width-1:0] bit_cnt;                  // Rising edges seen in this frame
    spi_pkg::data_t       rx_shift;
    spi_pkg::data_t       rx_next;                  // Byte including the bit on mosi now
    spi_pkg::data_t       tx_shift;
    logic                 is_read;                  // Direction of the current frame
    logic                 rd_pending;               // rd_data lands this cycle
    logic                 byte1_done;
    logic                 byte2_done;

    assign sclk_rise  = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall  = ~sclk_sync[1] & sclk_sync[2];
    assign cs_idle    = cs_sync[1];
    assign mosi_s     = mosi_sync[1];
    assign rx_next    = {rx_shift[spi_pkg::data_width-2:0], mosi_s};
    assign byte1_done = sclk_rise & ~cs_idle & (bit_cnt == cnt_width'(spi_pkg::data_width - 1));
    assign byte2_done = sclk_rise & ~cs_idle & (bit_cnt == cnt_width'(spi_pkg::frame_bits - 1));
    assign miso       = tx_shift[spi_pkg::data_width-1];  // MSB first

    ////////////////////////////////
    // Synchronizers and frame control
    ////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            sclk_sync    <= '0;
            cs_sync      <= '1;                     // Deselected
            mosi_sync    <= '0;
            bit_cnt      <= '0;
            is_read      <= 1'b0;
            bus.read_en  <= 1'b0;
            bus.write_en <= 1'b0;
            rd_pending   <= 1'b0;
        end else begin
            sclk_sync    <= {sclk_sync[1:0], spi_clock};
            cs_sync      <= {cs_sync[0], cs_n};
            mosi_sync    <= {mosi_sync[0], mosi};
            bus.read_en  <= byte1_done & rx_next[spi_pkg::read_flag_bit];
            bus.write_en <= byte2_done & ~is_read;
            rd_pending   <= bus.read_en;
            if (cs_idle) begin
                bit_cnt <= '0;                      // Drops a partial frame
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 1'b1;          // Wraps after 16 bits
            end
            if (byte1_done) begin
                is_read <= rx_next[spi_pkg::read_flag_bit];
            end
        end
    end

    // Receive path and captured fields
    always_ff @(posedge clock) begin
        if (sclk_rise) begin
            rx_shift <= rx_next;
        end
        if (byte1_done) begin
            bus.address <= rx_next[spi_pkg::addr_width-1:0];  // Bit 6 ignored
        end
        if (byte2_done) begin
            bus.wr_data <= rx_next;
        end
    end

    ////////////////////////////////
    // Transmit path
    ////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            tx_shift <= '0;
        end else if (cs_idle) begin
            tx_shift <= '0;
        end else if (rd_pending) begin
            tx_shift <= bus.rd_data;                // MSB out before 9th rise
        end else if (sclk_fall) begin
            if (bit_cnt == '0) begin
                tx_shift <= '0;                     // Frame over, miso back to 0
            end else if (bit_cnt > cnt_width'(spi_pkg::data_width)) begin
                tx_shift <= {tx_shift[spi_pkg::data_width-2:0], 1'b0};
            end
        end
    end

    // One read per frame, so the strobe never stretches
    read_single_pulse: assert property (
        @(posedge clock) disable iff (!reset_n) bus.read_en |=> !bus.read_en
    );

endmodule
